// ==== include/pinmux_config.svh ====
// Pinmux subsystem configuration
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// Bus geometry
`define PINMUX_REG_ADDR_W  10
`define PINMUX_DATA_W      32
`define PINMUX_PAD_N       16

// Block select codes, address bits 9 to 7
`define PINMUX_SEL_GPIO    3'b001
`define PINMUX_SEL_TIMER   3'b011
`define PINMUX_SEL_SEMA    3'b100

// GPIO word offsets
`define PINMUX_GPIO_DIR       5'd0
`define PINMUX_GPIO_OUT       5'd1
`define PINMUX_GPIO_IN        5'd2
`define PINMUX_GPIO_INT_EN    5'd3
`define PINMUX_GPIO_INT_STAT  5'd4
`define PINMUX_GPIO_FUNC_SEL  5'd5

// Timer word offsets
`define PINMUX_TMR_CTRL    5'd0
`define PINMUX_TMR_LOAD    5'd1
`define PINMUX_TMR_COUNT   5'd2
`define PINMUX_TMR_STAT    5'd3

// mclk cycles per timer tick
`define PINMUX_TICK_DIV    4

// Hardware semaphores, offsets 1 and up
`define PINMUX_SEMA_N      15

`endif

// ==== hw/pinmux_pkg.sv ====
// Pinmux shared types
`default_nettype none

`include "pinmux_config.svh"

package pinmux_pkg;

   // ----------------------------------------
   // Register access seen by every block
   // ----------------------------------------
   typedef struct packed {
      logic                      wr;      // 1 = write, 0 = read
      logic [4:0]                offset;  // Word offset, addr bits 6 to 2
      logic [`PINMUX_DATA_W-1:0] wdata;
   } reg_req_t;

   // Interrupt lines out of the subsystem
   typedef struct packed {
      logic gpio;
      logic timer;
   } irq_t;

   // Pad side drive
   typedef struct packed {
      logic [`PINMUX_PAD_N-1:0] out;
      logic [`PINMUX_PAD_N-1:0] oen;  // Active low output enable
   } pad_bus_t;

   // ----------------------------------------
   // Block select, same codes as address bits 9 to 7
   // ----------------------------------------
   typedef enum logic [2:0] {
      BLK_NONE  = 3'b000,
      BLK_GPIO  = `PINMUX_SEL_GPIO,
      BLK_TIMER = `PINMUX_SEL_TIMER,
      BLK_SEMA  = `PINMUX_SEL_SEMA
   } blk_sel_e;

endpackage

`default_nettype wire

// ==== hw/pad_mux.sv ====
// Pad function multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module pad_mux (
   input  logic [`PINMUX_PAD_N-1:0] gpio_out_i,
   input  logic [`PINMUX_PAD_N-1:0] gpio_dir_i,
   input  logic [`PINMUX_PAD_N-1:0] func_sel_i,
   input  logic [`PINMUX_PAD_N-1:0] pad_in_i,
   input  logic                     uart_txd_i,
   output pinmux_pkg::pad_bus_t     pads_o,
   output logic                     uart_rxd_o
);

   always_comb begin
      // GPIO by default, DIR 1 drives the pad
      pads_o.out = gpio_out_i;
      pads_o.oen = ~gpio_dir_i;

      // Pad 0 as UART transmit
      if (func_sel_i[0]) begin
         pads_o.out[0] = uart_txd_i;
         pads_o.oen[0] = 1'b0;
      end

      // Pad 1 as UART receive, output off
      if (func_sel_i[1]) begin
         pads_o.oen[1] = 1'b1;
      end
   end

   // Idle line high when receive is not routed
   assign uart_rxd_o = func_sel_i[1] ? pad_in_i[1] : 1'b1;

endmodule

`default_nettype wire

// ==== hw/semaphore_regs.sv ====
// Hardware semaphore bank
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module semaphore_regs (
   input  logic                      mclk,
   input  logic                      reset_i,
   input  pinmux_pkg::reg_req_t      req_i,
   input  logic                      stb_i,
   output logic [`PINMUX_DATA_W-1:0] rdata_o
);

   localparam int SEMA_N = `PINMUX_SEMA_N;

   // Lock n lives at offset n, bit 0 unused
   logic [SEMA_N:1] lock_q;

   // ----------------------------------------
   // Lock state, changes only at the strobe
   // ----------------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         lock_q <= '0;
      end else if (stb_i) begin
         for (int i = 1; i <= SEMA_N; i++) begin
            if (req_i.offset == 5'(i)) begin
               if (!req_i.wr) begin
                  // Read takes the lock, already taken stays taken
                  lock_q[i] <= 1'b1;
               end else if (req_i.wdata[0]) begin
                  lock_q[i] <= 1'b0;
               end
            end
         end
      end
   end

   // Read value is the grant, sampled before the take
   always_comb begin
      rdata_o = '0;
      if (req_i.offset == 5'd0) begin
         // Bitmap view, no side effect
         rdata_o[SEMA_N:1] = lock_q;
      end else begin
         for (int i = 1; i <= SEMA_N; i++) begin
            if (req_i.offset == 5'(i)) begin
               rdata_o[0] = ~lock_q[i];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/timer_unit.sv ====
// Prescaled down-counting timer
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module timer_unit (
   input  logic                      mclk,
   input  logic                      reset_i,
   input  pinmux_pkg::reg_req_t      req_i,
   input  logic                      stb_i,
   output logic [`PINMUX_DATA_W-1:0] rdata_o,
   output logic                      irq_o
);

   localparam int DATA_W = `PINMUX_DATA_W;
   localparam int PRE_W  = $clog2(`PINMUX_TICK_DIV);

   logic              wr_en;
   logic              en_q;
   logic [PRE_W-1:0]  pre_q;
   logic              tick;
   logic [DATA_W-1:0] load_q;
   logic [DATA_W-1:0] count_q;
   logic              stat_q;

   assign wr_en = stb_i & req_i.wr;

   // ----------------------------------------
   // Tick prescaler
   // ----------------------------------------
   assign tick = en_q && (pre_q == PRE_W'(`PINMUX_TICK_DIV - 1));

   always_ff @(posedge mclk) begin
      if (reset_i) begin
         pre_q <= '0;
      end else if (!en_q || tick) begin
         // Held at zero while stopped
         pre_q <= '0;
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   // ----------------------------------------
   // Control, counter and status
   // ----------------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         en_q    <= 1'b0;
         load_q  <= '0;
         count_q <= '0;
         stat_q  <= 1'b0;
      end else begin
         if (wr_en && req_i.offset == `PINMUX_TMR_CTRL) begin
            en_q <= req_i.wdata[0];
         end
         // Clear first so an expiry in the same cycle is kept
         if (wr_en && req_i.offset == `PINMUX_TMR_STAT && req_i.wdata[0]) begin
            stat_q <= 1'b0;
         end
         if (wr_en && req_i.offset == `PINMUX_TMR_LOAD) begin
            // LOAD write restarts the count
            load_q  <= req_i.wdata;
            count_q <= req_i.wdata;
         end else if (tick) begin
            if (count_q == '0) begin
               stat_q  <= 1'b1;
               count_q <= load_q;
            end else begin
               count_q <= count_q - 1'b1;
            end
         end
      end
   end

   // Read mux
   always_comb begin
      case (req_i.offset)
         `PINMUX_TMR_CTRL:  rdata_o = {{(DATA_W-1){1'b0}}, en_q};
         `PINMUX_TMR_LOAD:  rdata_o = load_q;
         `PINMUX_TMR_COUNT: rdata_o = count_q;
         `PINMUX_TMR_STAT:  rdata_o = {{(DATA_W-1){1'b0}}, stat_q};
         default:           rdata_o = '0;
      endcase
   end

   assign irq_o = stat_q;

endmodule

`default_nettype wire

// ==== hw/gpio_regs.sv ====
// GPIO register bank
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module gpio_regs (
   input  logic                      mclk,
   input  logic                      reset_i,
   input  pinmux_pkg::reg_req_t      req_i,
   input  logic                      stb_i,
   output logic [`PINMUX_DATA_W-1:0] rdata_o,
   input  logic [`PINMUX_PAD_N-1:0]  pad_in_i,
   output logic [`PINMUX_PAD_N-1:0]  gpio_out_o,
   output logic [`PINMUX_PAD_N-1:0]  gpio_dir_o,
   output logic [`PINMUX_PAD_N-1:0]  func_sel_o,
   output logic                      irq_o
);

   localparam int PAD_N = `PINMUX_PAD_N;

   logic             wr_en;
   logic [PAD_N-1:0] wdata;
   logic [PAD_N-1:0] dir_q;
   logic [PAD_N-1:0] out_q;
   logic [PAD_N-1:0] int_en_q;
   logic [PAD_N-1:0] int_stat_q;
   logic [PAD_N-1:0] func_sel_q;
   // Input synchronizer and edge history
   logic [PAD_N-1:0] in_meta_q;
   logic [PAD_N-1:0] in_sync_q;
   logic [PAD_N-1:0] in_prev_q;
   logic [PAD_N-1:0] rise;
   logic [PAD_N-1:0] stat_clr;

   assign wr_en = stb_i & req_i.wr;
   assign wdata = req_i.wdata[PAD_N-1:0];

   // ----------------------------------------
   // Pad input path
   // ----------------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         in_meta_q <= '0;
         in_sync_q <= '0;
         in_prev_q <= '0;
      end else begin
         in_meta_q <= pad_in_i;
         in_sync_q <= in_meta_q;
         in_prev_q <= in_sync_q;
      end
   end

   // Rising edge on the synchronized input
   assign rise = in_sync_q & ~in_prev_q;

   // Write 1 to clear, a new edge wins over the clear
   assign stat_clr = (wr_en && req_i.offset == `PINMUX_GPIO_INT_STAT) ? wdata : '0;

   // ----------------------------------------
   // Config registers
   // ----------------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         dir_q      <= '0;
         out_q      <= '0;
         int_en_q   <= '0;
         int_stat_q <= '0;
         func_sel_q <= '0;
      end else begin
         int_stat_q <= (int_stat_q & ~stat_clr) | rise;
         if (wr_en) begin
            case (req_i.offset)
               `PINMUX_GPIO_DIR:      dir_q      <= wdata;
               `PINMUX_GPIO_OUT:      out_q      <= wdata;
               `PINMUX_GPIO_INT_EN:   int_en_q   <= wdata;
               `PINMUX_GPIO_FUNC_SEL: func_sel_q <= wdata;
               default: ;
            endcase
         end
      end
   end

   // Read mux, IN is read only
   always_comb begin
      rdata_o = '0;
      case (req_i.offset)
         `PINMUX_GPIO_DIR:      rdata_o[PAD_N-1:0] = dir_q;
         `PINMUX_GPIO_OUT:      rdata_o[PAD_N-1:0] = out_q;
         `PINMUX_GPIO_IN:       rdata_o[PAD_N-1:0] = in_sync_q;
         `PINMUX_GPIO_INT_EN:   rdata_o[PAD_N-1:0] = int_en_q;
         `PINMUX_GPIO_INT_STAT: rdata_o[PAD_N-1:0] = int_stat_q;
         `PINMUX_GPIO_FUNC_SEL: rdata_o[PAD_N-1:0] = func_sel_q;
         default: ;
      endcase
   end

   assign gpio_out_o = out_q;
   assign gpio_dir_o = dir_q;
   assign func_sel_o = func_sel_q;

   // Any enabled pending edge
   assign irq_o = |(int_stat_q & int_en_q);

endmodule

`default_nettype wire

// ==== hw/reg_router.sv ====
// Register bus block router
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module reg_router (
   input  logic                          mclk,
   input  logic                          reset_i,
   input  logic                          reg_cs_i,
   input  logic                          reg_wr_i,
   input  logic [`PINMUX_REG_ADDR_W-1:0] reg_addr_i,
   input  logic [`PINMUX_DATA_W-1:0]     reg_wdata_i,
   output logic [`PINMUX_DATA_W-1:0]     reg_rdata_o,
   output logic                          reg_ack_o,
   // Towards the blocks
   output pinmux_pkg::reg_req_t          req_o,
   output logic                          gpio_stb_o,
   output logic                          tmr_stb_o,
   output logic                          sema_stb_o,
   input  logic [`PINMUX_DATA_W-1:0]     gpio_rdata_i,
   input  logic [`PINMUX_DATA_W-1:0]     tmr_rdata_i,
   input  logic [`PINMUX_DATA_W-1:0]     sema_rdata_i
);

   pinmux_pkg::blk_sel_e       sel;
   logic                       ack_q;
   logic                       start;
   logic [`PINMUX_DATA_W-1:0]  blk_rdata;
   logic [`PINMUX_DATA_W-1:0]  rdata_q;

   // ----------------------------------------
   // Block decode from the top address bits
   // ----------------------------------------
   always_comb begin
      case (reg_addr_i[`PINMUX_REG_ADDR_W-1 -: 3])
         `PINMUX_SEL_GPIO:  sel = pinmux_pkg::BLK_GPIO;
         `PINMUX_SEL_TIMER: sel = pinmux_pkg::BLK_TIMER;
         `PINMUX_SEL_SEMA:  sel = pinmux_pkg::BLK_SEMA;
         // Dropped blocks and unmapped codes
         default:           sel = pinmux_pkg::BLK_NONE;
      endcase
   end

   // Shared request, word offset from bits 6 to 2
   assign req_o = '{wr: reg_wr_i, offset: reg_addr_i[6:2], wdata: reg_wdata_i};

   // New access: cs seen high while ack still low
   assign start = reg_cs_i & ~ack_q;

   // One-cycle strobes, the edge closing this cycle raises ack
   assign gpio_stb_o = start & (sel == pinmux_pkg::BLK_GPIO);
   assign tmr_stb_o  = start & (sel == pinmux_pkg::BLK_TIMER);
   assign sema_stb_o = start & (sel == pinmux_pkg::BLK_SEMA);

   // Response mux
   always_comb begin
      case (sel)
         pinmux_pkg::BLK_GPIO:  blk_rdata = gpio_rdata_i;
         pinmux_pkg::BLK_TIMER: blk_rdata = tmr_rdata_i;
         pinmux_pkg::BLK_SEMA:  blk_rdata = sema_rdata_i;
         default:               blk_rdata = '0;
      endcase
   end

   // ----------------------------------------
   // Four-phase acknowledge
   // ----------------------------------------
   // ack follows cs by one edge in both directions
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= reg_cs_i;
      end
   end

   // Read data captured with the rising ack, held while ack is high
   always_ff @(posedge mclk) begin
      if (start) begin
         rdata_q <= blk_rdata;
      end
   end

   assign reg_ack_o   = ack_q;
   assign reg_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== hw/pinmux_top.sv ====
// Pinmux subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module pinmux_top (
   input  logic                          mclk,
   input  logic                          reset_i,
   // Register bus
   input  logic                          reg_cs_i,
   input  logic                          reg_wr_i,
   input  logic [`PINMUX_REG_ADDR_W-1:0] reg_addr_i,
   input  logic [`PINMUX_DATA_W-1:0]     reg_wdata_i,
   output logic [`PINMUX_DATA_W-1:0]     reg_rdata_o,
   output logic                          reg_ack_o,
   // Pads
   input  logic [`PINMUX_PAD_N-1:0]      pad_in_i,
   output pinmux_pkg::pad_bus_t          pads_o,
   // UART
   input  logic                          uart_txd_i,
   output logic                          uart_rxd_o,
   // Interrupts
   output pinmux_pkg::irq_t              irq_o
);

   pinmux_pkg::reg_req_t         req;
   logic                         gpio_stb;
   logic                         tmr_stb;
   logic                         sema_stb;
   logic [`PINMUX_DATA_W-1:0]    gpio_rdata;
   logic [`PINMUX_DATA_W-1:0]    tmr_rdata;
   logic [`PINMUX_DATA_W-1:0]    sema_rdata;

   // GPIO config towards the pad mux
   logic [`PINMUX_PAD_N-1:0]     gpio_out;
   logic [`PINMUX_PAD_N-1:0]     gpio_dir;
   logic [`PINMUX_PAD_N-1:0]     func_sel;

   logic                         gpio_irq;
   logic                         tmr_irq;

   assign irq_o = '{gpio: gpio_irq, timer: tmr_irq};

   // ----------------------------------------
   // Decode and response path
   // ----------------------------------------
   reg_router u_router (
      .mclk         (mclk),
      .reset_i      (reset_i),
      .reg_cs_i     (reg_cs_i),
      .reg_wr_i     (reg_wr_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_rdata_o  (reg_rdata_o),
      .reg_ack_o    (reg_ack_o),
      .req_o        (req),
      .gpio_stb_o   (gpio_stb),
      .tmr_stb_o    (tmr_stb),
      .sema_stb_o   (sema_stb),
      .gpio_rdata_i (gpio_rdata),
      .tmr_rdata_i  (tmr_rdata),
      .sema_rdata_i (sema_rdata)
   );

   // ----------------------------------------
   // Peripherals
   // ----------------------------------------
   gpio_regs u_gpio (
      .mclk       (mclk),
      .reset_i    (reset_i),
      .req_i      (req),
      .stb_i      (gpio_stb),
      .rdata_o    (gpio_rdata),
      .pad_in_i   (pad_in_i),
      .gpio_out_o (gpio_out),
      .gpio_dir_o (gpio_dir),
      .func_sel_o (func_sel),
      .irq_o      (gpio_irq)
   );

   timer_unit u_timer (
      .mclk    (mclk),
      .reset_i (reset_i),
      .req_i   (req),
      .stb_i   (tmr_stb),
      .rdata_o (tmr_rdata),
      .irq_o   (tmr_irq)
   );

   semaphore_regs u_sema (
      .mclk    (mclk),
      .reset_i (reset_i),
      .req_i   (req),
      .stb_i   (sema_stb),
      .rdata_o (sema_rdata)
   );

   // Pad routing
   pad_mux u_pad_mux (
      .gpio_out_i (gpio_out),
      .gpio_dir_i (gpio_dir),
      .func_sel_i (func_sel),
      .pad_in_i   (pad_in_i),
      .uart_txd_i (uart_txd_i),
      .pads_o     (pads_o),
      .uart_rxd_o (uart_rxd_o)
   );

endmodule

`default_nettype wire

// ==== tests/pinmux_chk.sv ====
// Register bus protocol checks
`timescale 1ns/1ps
`default_nettype none

module pinmux_chk (
   input logic mclk,
   input logic reset_i,
   input logic cs_i,
   input logic ack_i,
   input logic gpio_stb_i,
   input logic tmr_stb_i,
   input logic sema_stb_i
);

   // ----------------------------------------
   // Four-phase handshake
   // ----------------------------------------
   // A rising ack needs cs seen high on the edge before
   ack_needs_cs: assert property (@(posedge mclk) disable iff (reset_i)
      $rose(ack_i) |-> $past(cs_i))
      else $error("ack rose without a preceding cs");

   // cs sampled low, ack low by the next edge
   ack_drops: assert property (@(posedge mclk) disable iff (reset_i)
      !cs_i |=> !ack_i)
      else $error("ack still high one cycle after cs dropped");

   // One block strobed at a time
   one_strobe: assert property (@(posedge mclk) disable iff (reset_i)
      $onehot0({gpio_stb_i, tmr_stb_i, sema_stb_i}))
      else $error("more than one block strobe active");

endmodule

`default_nettype wire

// ==== tests/pinmux_tb.sv ====
// Pinmux subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "pinmux_config.svh"

module pinmux_tb;

   localparam int          CLK_PERIOD  = 10;
   localparam int          ACK_LIMIT   = 16;
   // Six tests of a few hundred cycles each at most
   localparam int          TEST_CYCLES = 2000;
   localparam int          WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD;
   localparam logic [31:0] RAND_SEED   = 32'hbcaa136f;

   logic                          mclk = 1'b0;
   logic                          reset_i;
   logic                          reg_cs_i;
   logic                          reg_wr_i;
   logic [`PINMUX_REG_ADDR_W-1:0] reg_addr_i;
   logic [`PINMUX_DATA_W-1:0]     reg_wdata_i;
   logic [`PINMUX_DATA_W-1:0]     reg_rdata_o;
   logic                          reg_ack_o;
   logic [`PINMUX_PAD_N-1:0]      pad_in_i;
   pinmux_pkg::pad_bus_t          pads_o;
   logic                          uart_txd_i;
   logic                          uart_rxd_o;
   pinmux_pkg::irq_t              irq_o;

   int unsigned                   cyc = 0;
   // GPIO config from test 1 for the later tests
   logic [`PINMUX_PAD_N-1:0]      dir_val;
   logic [`PINMUX_PAD_N-1:0]      out_val;

   bind pinmux_top pinmux_chk u_chk (
      .mclk       (mclk),
      .reset_i    (reset_i),
      .cs_i       (reg_cs_i),
      .ack_i      (reg_ack_o),
      .gpio_stb_i (gpio_stb),
      .tmr_stb_i  (tmr_stb),
      .sema_stb_i (sema_stb)
   );

   pinmux_top uut (
      .mclk        (mclk),
      .reset_i     (reset_i),
      .reg_cs_i    (reg_cs_i),
      .reg_wr_i    (reg_wr_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_rdata_o (reg_rdata_o),
      .reg_ack_o   (reg_ack_o),
      .pad_in_i    (pad_in_i),
      .pads_o      (pads_o),
      .uart_txd_i  (uart_txd_i),
      .uart_rxd_o  (uart_rxd_o),
      .irq_o       (irq_o)
   );

   always #(CLK_PERIOD / 2) mclk = ~mclk;

   // Cycle count for bounded polling
   always @(posedge mclk) cyc <= cyc + 1;

   // ----------------------------------------
   // Failure, compare and bus tasks
   // ----------------------------------------
   task automatic stop_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_word(input string name, input logic [`PINMUX_DATA_W-1:0] got,
                             input logic [`PINMUX_DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_pads(input string name, input pinmux_pkg::pad_bus_t got,
                             input pinmux_pkg::pad_bus_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got out %h oen %h, expected out %h oen %h",
                  name, got.out, got.oen, exp.out, exp.oen);
         stop_with_failure();
      end
   endtask

   task automatic check_irq(input string name, input pinmux_pkg::irq_t got,
                            input pinmux_pkg::irq_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   // Byte address from block code and word offset
   function automatic logic [`PINMUX_REG_ADDR_W-1:0] reg_addr(input pinmux_pkg::blk_sel_e sel,
                                                              input logic [4:0] off);
      return {sel, off, 2'b00};
   endfunction

   // Bounded falling-edge poll of ack
   task automatic wait_ack(input logic level);
      int waited;
      waited = 0;
      do begin
         @(negedge mclk);
         waited++;
      end while (reg_ack_o !== level && waited < ACK_LIMIT);
      if (reg_ack_o !== level) begin
         $display("Bus handshake timed out waiting for ack to go to %0d", level);
         stop_with_failure();
      end
   endtask

   // Callers enter and return on a falling edge
   task automatic bus_write(input pinmux_pkg::blk_sel_e sel, input logic [4:0] off,
                            input logic [`PINMUX_DATA_W-1:0] data);
      reg_cs_i    = 1'b1;
      reg_wr_i    = 1'b1;
      reg_addr_i  = reg_addr(sel, off);
      reg_wdata_i = data;
      wait_ack(1'b1);
      reg_cs_i = 1'b0;
      reg_wr_i = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic bus_read(input pinmux_pkg::blk_sel_e sel, input logic [4:0] off,
                           output logic [`PINMUX_DATA_W-1:0] data);
      reg_cs_i   = 1'b1;
      reg_wr_i   = 1'b0;
      reg_addr_i = reg_addr(sel, off);
      wait_ack(1'b1);
      data     = reg_rdata_o;
      reg_cs_i = 1'b0;
      wait_ack(1'b0);
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------
   task automatic test_reg_readback();
      logic [31:0] rnd_dir;
      logic [31:0] rnd_out;
      logic [31:0] rd;
      rnd_dir = $urandom();
      rnd_out = $urandom();
      dir_val = rnd_dir[15:0];
      out_val = rnd_out[15:0];
      // Full-word writes store only the pad bits
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_DIR, rnd_dir);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_OUT, rnd_out);
      bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_DIR, rd);
      check_word("gpio dir", rd, {16'h0, dir_val});
      bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_OUT, rd);
      check_word("gpio out", rd, {16'h0, out_val});
      // Unmapped block still acks and reads zero
      bus_write(pinmux_pkg::BLK_NONE, 5'd1, 32'hffff_ffff);
      bus_read(pinmux_pkg::BLK_NONE, 5'd1, rd);
      check_word("unmapped read", rd, 32'h0);
   endtask

   task automatic test_pad_drive();
      pinmux_pkg::pad_bus_t exp_pads;
      logic [31:0]          rnd;
      logic [31:0]          rd;
      int unsigned          start;
      exp_pads.out = out_val;
      exp_pads.oen = ~dir_val;
      check_pads("pads gpio", pads_o, exp_pads);
      rnd      = $urandom();
      pad_in_i = rnd[15:0];
      start    = cyc;
      // Poll IN for up to five cycles behind the two-flop sync
      do begin
         bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_IN, rd);
      end while (rd !== {16'h0, rnd[15:0]} && (cyc - start) < 5);
      check_word("gpio in", rd, {16'h0, rnd[15:0]});
   endtask

   task automatic test_edge_irq();
      pinmux_pkg::irq_t exp_irq;
      logic [31:0]      rd;
      pad_in_i = '0;
      repeat (4) @(negedge mclk);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, 32'h0000_ffff);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_EN, 32'h0000_0010);
      // Enabled pad 4 rises and sets status one cycle after sync
      pad_in_i = 16'h0010;
      repeat (4) @(negedge mclk);
      bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, rd);
      check_word("gpio int_stat set", rd, 32'h0000_0010);
      exp_irq.gpio  = 1'b1;
      exp_irq.timer = 1'b0;
      check_irq("irq on enabled edge", irq_o, exp_irq);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, 32'h0000_0010);
      bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, rd);
      check_word("gpio int_stat cleared", rd, 32'h0);
      exp_irq.gpio = 1'b0;
      check_irq("irq after clear", irq_o, exp_irq);
      // Pad 7 not enabled so status only
      pad_in_i = 16'h0090;
      repeat (4) @(negedge mclk);
      check_irq("irq on disabled edge", irq_o, exp_irq);
      bus_read(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, rd);
      check_word("gpio int_stat disabled pad", rd, 32'h0000_0080);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_STAT, 32'h0000_ffff);
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_INT_EN, 32'h0);
   endtask

   task automatic test_uart_mux();
      pinmux_pkg::pad_bus_t exp_pads;
      // Pad 0 as GPIO input and pad 1 as GPIO output, so both overrides show
      dir_val = (dir_val & 16'hfffe) | 16'h0002;
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_DIR, {16'h0, dir_val});
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_FUNC_SEL, 32'h3);
      exp_pads.oen    = ~dir_val;
      exp_pads.oen[0] = 1'b0;
      exp_pads.oen[1] = 1'b1;
      exp_pads.out    = out_val;
      for (int b = 0; b < 2; b++) begin
         uart_txd_i      = b[0];
         pad_in_i        = b[0] ? 16'h0002 : 16'h0000;
         exp_pads.out[0] = b[0];
         @(negedge mclk);
         check_pads("pads uart", pads_o, exp_pads);
         check_word("uart rxd", {31'h0, uart_rxd_o}, {31'h0, b[0]});
      end
      // Line idles high when receive is not routed
      bus_write(pinmux_pkg::BLK_GPIO, `PINMUX_GPIO_FUNC_SEL, 32'h0);
      pad_in_i = 16'h0000;
      @(negedge mclk);
      check_word("uart rxd idle", {31'h0, uart_rxd_o}, 32'h1);
   endtask

   task automatic test_timer();
      pinmux_pkg::irq_t exp_irq;
      logic [31:0]      rd;
      int               waited;
      bus_write(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_LOAD, 32'd5);
      bus_write(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_CTRL, 32'd1);
      waited = 0;
      while (!irq_o.timer && waited < 200) begin
         @(negedge mclk);
         waited++;
      end
      if (!irq_o.timer) begin
         $display("Timer interrupt did not rise within 200 cycles");
         stop_with_failure();
      end
      exp_irq.gpio  = 1'b0;
      exp_irq.timer = 1'b1;
      check_irq("irq timer expiry", irq_o, exp_irq);
      bus_read(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_STAT, rd);
      check_word("timer stat set", rd, 32'h1);
      bus_write(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_STAT, 32'h1);
      bus_read(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_STAT, rd);
      check_word("timer stat cleared", rd, 32'h0);
      exp_irq.timer = 1'b0;
      check_irq("irq timer cleared", irq_o, exp_irq);
      bus_write(pinmux_pkg::BLK_TIMER, `PINMUX_TMR_CTRL, 32'd0);
   endtask

   task automatic test_semaphore();
      logic [31:0] rd;
      bus_read(pinmux_pkg::BLK_SEMA, 5'd3, rd);
      check_word("lock 3 first take", rd, 32'h1);
      bus_read(pinmux_pkg::BLK_SEMA, 5'd3, rd);
      check_word("lock 3 second take", rd, 32'h0);
      bus_read(pinmux_pkg::BLK_SEMA, 5'd0, rd);
      check_word("sema bitmap held", rd, 32'h8);
      bus_write(pinmux_pkg::BLK_SEMA, 5'd3, 32'h1);
      bus_read(pinmux_pkg::BLK_SEMA, 5'd0, rd);
      check_word("sema bitmap released", rd, 32'h0);
      bus_read(pinmux_pkg::BLK_SEMA, 5'd3, rd);
      check_word("lock 3 retake", rd, 32'h1);
   endtask

   // ----------------------------------------
   // Sequence and watchdog
   // ----------------------------------------
   initial begin
      pinmux_pkg::pad_bus_t idle_pads;
      pinmux_pkg::irq_t     idle_irq;
      void'($urandom(RAND_SEED));
      reset_i     = 1'b1;
      reg_cs_i    = 1'b0;
      reg_wr_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      pad_in_i    = '0;
      uart_txd_i  = 1'b1;
      repeat (4) @(posedge mclk);
      @(negedge mclk);
      reset_i = 1'b0;
      @(negedge mclk);
      // Reset state with all pads as inputs
      idle_pads.out = '0;
      idle_pads.oen = '1;
      idle_irq      = '0;
      check_pads("pads after reset", pads_o, idle_pads);
      check_irq("irq after reset", irq_o, idle_irq);
      check_word("ack after reset", {31'h0, reg_ack_o}, 32'h0);
      check_word("uart rxd after reset", {31'h0, uart_rxd_o}, 32'h1);
      test_reg_readback();
      test_pad_drive();
      test_edge_irq();
      test_uart_mux();
      test_timer();
      test_semaphore();
      $display("=== PASS ===");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      stop_with_failure();
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/pinmux_pkg.sv
hw/pad_mux.sv
hw/semaphore_regs.sv
hw/timer_unit.sv
hw/gpio_regs.sv
hw/reg_router.sv
hw/pinmux_top.sv
tests/pinmux_chk.sv
tests/pinmux_tb.sv

// ==== Makefile ====
# Verilator build for the pinmux subsystem
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pinmux_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
